// File: design/gpuPkg.sv
package gpuPkg;

  // Bits per colour channel.
  parameter int CHANNEL_BITS = 8;

  // One pixel colour with red in the upper byte.
  typedef struct packed
  {
    logic [CHANNEL_BITS-1:0] r;
    logic [CHANNEL_BITS-1:0] g;
    logic [CHANNEL_BITS-1:0] b;
  } rgb_t;

  // Sequencer states.
  // Each span state draws one horizontal chord of the filled circle.
  typedef enum logic [2:0]
  {
    SPAN_IDLE          = 3'd0, // Waits for a valid step or the end of the circle.
    SPAN_BOTTOM_WIDE   = 3'd1, // Row yC + offA, half-width offB.
    SPAN_BOTTOM_NARROW = 3'd2, // Row yC + offB, half-width offA.
    SPAN_TOP_WIDE      = 3'd3, // Row yC - offA, half-width offB.
    SPAN_TOP_NARROW    = 3'd4, // Row yC - offB, half-width offA.
    SPAN_STEP          = 3'd5  // Requests the next midpoint step.
  } spanState_t;

endpackage

// File: design/circleCmdLatch.sv
`timescale 1ns/100ps

module circleCmdLatch
#(
  parameter int widthBits = 10,
  parameter int heightBits = 9
)
(
  input logic clk,
  input logic n_rst,
  input logic start_i,
  input logic [widthBits-1:0] xC_i,
  input logic [heightBits-1:0] yC_i,
  input logic [widthBits-1:0] rad_i,
  input gpuPkg::rgb_t color_i,
  input logic drawEnd_i,
  output logic launch_o,
  output logic busy_o,
  output logic done_o,
  output logic [widthBits-1:0] xC_o,
  output logic [heightBits-1:0] yC_o,
  output logic [widthBits-1:0] rad_o,
  output gpuPkg::rgb_t color_o
);
  import gpuPkg::*;

  logic startDly;
  logic accept;

  // A new command is only taken on a rising edge while idle.
  assign accept = start_i && !startDly && !busy_o;

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
    begin
      startDly <= 1'b0;
      launch_o <= 1'b0;
      busy_o <= 1'b0;
      done_o <= 1'b0;
    end
    else
    begin
      startDly <= start_i;
      launch_o <= accept;
      done_o <= drawEnd_i && busy_o; // Falls together with busy.
      if (accept)
      begin
        busy_o <= 1'b1;
      end
      else if (drawEnd_i)
      begin
        busy_o <= 1'b0;
      end
    end
  end

  // Command registers hold still for the whole draw.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      xC_o <= xC_i;
      yC_o <= yC_i;
      rad_o <= rad_i;
      color_o <= color_i;
    end
  end

endmodule

// File: design/midpointStepper.sv
`timescale 1ns/100ps

module midpointStepper
#(
  parameter int widthBits = 10
)
(
  input logic clk,
  input logic n_rst,
  input logic launch_i,
  input logic [widthBits-1:0] rad_i,
  input logic stepNext_i,
  output logic signed [widthBits:0] offA_o,
  output logic signed [widthBits:0] offB_o,
  output logic stepValid_o,
  output logic stepsDone_o
);

  // Decision variable needs headroom for 2 * offset terms.
  localparam int decBits = widthBits + 2;

  logic signed [decBits-1:0] dec;
  logic signed [decBits-1:0] decNext;
  logic signed [decBits-1:0] aWide;
  logic signed [decBits-1:0] bWide;
  logic signed [widthBits:0] aNext;
  logic signed [widthBits:0] bNext;

  assign aWide = decBits'(offA_o);
  assign bWide = decBits'(offB_o);
  assign aNext = offA_o + (widthBits+1)'(1);

  // The octant is finished once offA passes offB.
  assign stepValid_o = (offA_o <= offB_o);

  always_comb
  begin
    if (dec[decBits-1])
    begin
      decNext = dec + (aWide <<< 1) + decBits'(3); // The midpoint is inside so offB stays.
      bNext = offB_o;
    end
    else
    begin
      decNext = dec + ((aWide - bWide) <<< 1) + decBits'(5);
      bNext = offB_o - (widthBits+1)'(1);
    end
  end

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
    begin
      offA_o <= (widthBits+1)'(1); // offA > offB keeps the stepper invalid until launch.
      offB_o <= '0;
      dec <= '0;
      stepsDone_o <= 1'b0;
    end
    else if (launch_i)
    begin
      offA_o <= '0;
      offB_o <= $signed({1'b0, rad_i});
      dec <= decBits'(1) - $signed({2'b00, rad_i});
      stepsDone_o <= 1'b0;
    end
    else if (stepNext_i && stepValid_o)
    begin
      offA_o <= aNext;
      offB_o <= bNext;
      dec <= decNext;
      stepsDone_o <= (aNext > bNext); // One-cycle pulse after the last step.
    end
    else
    begin
      stepsDone_o <= 1'b0;
    end
  end

endmodule

// File: design/spanSequencer.sv
`timescale 1ns/100ps

module spanSequencer
#(
  parameter int widthBits = 10,
  parameter int heightBits = 9
)
(
  input logic clk,
  input logic n_rst,
  input logic [widthBits-1:0] xC_i,
  input logic [heightBits-1:0] yC_i,
  input gpuPkg::rgb_t color_i,
  input logic signed [widthBits:0] offA_i,
  input logic signed [widthBits:0] offB_i,
  input logic stepValid_i,
  input logic stepsDone_i,
  output logic stepNext_o,
  output logic drawEnd_o,
  output logic pixValid_o,
  output logic signed [widthBits:0] pixX_o,
  output logic signed [heightBits:0] pixY_o,
  output gpuPkg::rgb_t pixColor_o
);
  import gpuPkg::*;

  // Common width for the row sum so that either offset fits next to yC.
  localparam int sumBits = ((widthBits > heightBits) ? widthBits : heightBits) + 1;

  spanState_t state;
  spanState_t stateNext;
  logic loadSpan;
  logic lastPix;
  logic spanNext;
  logic signed [widthBits:0] xCenter;
  logic signed [widthBits:0] rowOff;
  logic signed [widthBits:0] halfW;
  logic signed [widthBits:0] xLeft;
  logic signed [widthBits:0] xRight;
  logic signed [widthBits:0] xEnd;
  logic signed [sumBits-1:0] yCenter;
  logic signed [sumBits-1:0] yShift;
  logic signed [sumBits-1:0] ySum;
  logic signed [heightBits:0] ySpan;

  assign lastPix = (pixX_o == xEnd);
  assign spanNext = (stateNext != SPAN_IDLE) && (stateNext != SPAN_STEP);

  always_comb
  begin
    stateNext = state;
    loadSpan = 1'b0;
    stepNext_o = 1'b0;
    drawEnd_o = 1'b0;
    case (state)
      SPAN_IDLE:
      begin
        if (stepValid_i)
        begin
          stateNext = SPAN_BOTTOM_WIDE;
          loadSpan = 1'b1;
        end
        else if (stepsDone_i)
        begin
          drawEnd_o = 1'b1; // No step is left so the circle is complete.
        end
      end
      SPAN_BOTTOM_WIDE:
      begin
        if (lastPix)
        begin
          stateNext = SPAN_BOTTOM_NARROW;
          loadSpan = 1'b1;
        end
      end
      SPAN_BOTTOM_NARROW:
      begin
        if (lastPix)
        begin
          stateNext = SPAN_TOP_WIDE;
          loadSpan = 1'b1;
        end
      end
      SPAN_TOP_WIDE:
      begin
        if (lastPix)
        begin
          stateNext = SPAN_TOP_NARROW;
          loadSpan = 1'b1;
        end
      end
      SPAN_TOP_NARROW:
      begin
        if (lastPix)
        begin
          stateNext = SPAN_STEP;
        end
      end
      SPAN_STEP:
      begin
        stepNext_o = 1'b1; // Offsets are updated when we are back in idle.
        stateNext = SPAN_IDLE;
      end
      default:
      begin
        stateNext = SPAN_IDLE;
      end
    endcase
  end

  // Endpoints of the span that the next state draws.
  always_comb
  begin
    case (stateNext)
      SPAN_BOTTOM_NARROW, SPAN_TOP_NARROW:
      begin
        rowOff = offB_i;
        halfW = offA_i;
      end
      default:
      begin
        rowOff = offA_i;
        halfW = offB_i;
      end
    endcase
  end

  always_comb
  begin
    if ((stateNext == SPAN_BOTTOM_WIDE) || (stateNext == SPAN_BOTTOM_NARROW))
    begin
      ySum = yCenter + yShift;
    end
    else
    begin
      ySum = yCenter - yShift;
    end
  end

  assign xCenter = $signed({1'b0, xC_i});
  assign yCenter = sumBits'($signed({1'b0, yC_i}));
  assign yShift = sumBits'(rowOff);
  assign ySpan = ySum[heightBits:0];
  assign xLeft = xCenter - halfW;
  assign xRight = xCenter + halfW;

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
    begin
      state <= SPAN_IDLE;
      pixValid_o <= 1'b0;
    end
    else
    begin
      state <= stateNext;
      pixValid_o <= spanNext;
    end
  end

  always_ff @(posedge clk)
  begin
    if (loadSpan)
    begin
      pixX_o <= xLeft;
      xEnd <= xRight;
      pixY_o <= ySpan;
      pixColor_o <= color_i;
    end
    else if (pixValid_o && !lastPix)
    begin
      pixX_o <= pixX_o + (widthBits+1)'(1); // One pixel per clock.
    end
  end

endmodule

// File: design/pixelClipper.sv
`timescale 1ns/100ps

module pixelClipper
#(
  parameter int widthBits = 10,
  parameter int heightBits = 9,
  parameter int screenWidth = 640,
  parameter int screenHeight = 480
)
(
  input logic clk,
  input logic n_rst,
  input logic pixValid_i,
  input logic signed [widthBits:0] pixX_i,
  input logic signed [heightBits:0] pixY_i,
  input gpuPkg::rgb_t pixColor_i,
  output logic pixelValid_o,
  output logic [widthBits-1:0] pixelX_o,
  output logic [heightBits-1:0] pixelY_o,
  output gpuPkg::rgb_t pixelColor_o
);
  import gpuPkg::*;

  localparam logic signed [widthBits:0] xLimit = (widthBits+1)'(screenWidth);
  localparam logic signed [heightBits:0] yLimit = (heightBits+1)'(screenHeight);

  logic xInside;
  logic yInside;
  logic onScreen;

  // Sign bit set means the span ran off the left or top edge.
  assign xInside = !pixX_i[widthBits] && (pixX_i < xLimit);
  assign yInside = !pixY_i[heightBits] && (pixY_i < yLimit);
  assign onScreen = pixValid_i && xInside && yInside;

  always_ff @(posedge clk, negedge n_rst)
  begin
    if (!n_rst)
    begin
      pixelValid_o <= 1'b0;
    end
    else
    begin
      pixelValid_o <= onScreen;
    end
  end

  always_ff @(posedge clk)
  begin
    if (onScreen)
    begin
      pixelX_o <= pixX_i[widthBits-1:0];
      pixelY_o <= pixY_i[heightBits-1:0];
      pixelColor_o <= pixColor_i;
    end
  end

endmodule

// File: design/gpuFillCircle.sv
`timescale 1ns/100ps

module gpuFillCircle
#(
  parameter int widthBits = 10,
  parameter int heightBits = 9,
  parameter int screenWidth = 640,
  parameter int screenHeight = 480
)
(
  input logic clk,
  input logic n_rst,
  input logic [widthBits-1:0] xC_i,
  input logic [heightBits-1:0] yC_i,
  input logic [widthBits-1:0] rad_i,
  input gpuPkg::rgb_t color_i,
  input logic start_i,
  output logic busy_o,
  output logic done_o,
  output logic pixelValid_o,
  output logic [widthBits-1:0] pixelX_o,
  output logic [heightBits-1:0] pixelY_o,
  output gpuPkg::rgb_t pixelColor_o
);
  import gpuPkg::*;

  logic launch;
  logic [widthBits-1:0] xCLatched;
  logic [heightBits-1:0] yCLatched;
  logic [widthBits-1:0] radLatched;
  rgb_t colorLatched;
  logic signed [widthBits:0] offA;
  logic signed [widthBits:0] offB;
  logic stepValid;
  logic stepsDone;
  logic stepNext;
  logic drawEnd;
  logic pixValid;
  logic signed [widthBits:0] pixX;
  logic signed [heightBits:0] pixY;
  rgb_t pixColor;

  circleCmdLatch #(
    .widthBits(widthBits),
    .heightBits(heightBits)
  ) cmdLatch (
    .clk(clk),
    .n_rst(n_rst),
    .start_i(start_i),
    .xC_i(xC_i),
    .yC_i(yC_i),
    .rad_i(rad_i),
    .color_i(color_i),
    .drawEnd_i(drawEnd),
    .launch_o(launch),
    .busy_o(busy_o),
    .done_o(done_o),
    .xC_o(xCLatched),
    .yC_o(yCLatched),
    .rad_o(radLatched),
    .color_o(colorLatched)
  );

  midpointStepper #(
    .widthBits(widthBits)
  ) stepper (
    .clk(clk),
    .n_rst(n_rst),
    .launch_i(launch),
    .rad_i(radLatched),
    .stepNext_i(stepNext),
    .offA_o(offA),
    .offB_o(offB),
    .stepValid_o(stepValid),
    .stepsDone_o(stepsDone)
  );

  spanSequencer #(
    .widthBits(widthBits),
    .heightBits(heightBits)
  ) sequencer (
    .clk(clk),
    .n_rst(n_rst),
    .xC_i(xCLatched),
    .yC_i(yCLatched),
    .color_i(colorLatched),
    .offA_i(offA),
    .offB_i(offB),
    .stepValid_i(stepValid),
    .stepsDone_i(stepsDone),
    .stepNext_o(stepNext),
    .drawEnd_o(drawEnd),
    .pixValid_o(pixValid),
    .pixX_o(pixX),
    .pixY_o(pixY),
    .pixColor_o(pixColor)
  );

  pixelClipper #(
    .widthBits(widthBits),
    .heightBits(heightBits),
    .screenWidth(screenWidth),
    .screenHeight(screenHeight)
  ) clipper (
    .clk(clk),
    .n_rst(n_rst),
    .pixValid_i(pixValid),
    .pixX_i(pixX),
    .pixY_i(pixY),
    .pixColor_i(pixColor),
    .pixelValid_o(pixelValid_o),
    .pixelX_o(pixelX_o),
    .pixelY_o(pixelY_o),
    .pixelColor_o(pixelColor_o)
  );

endmodule

// File: verif/gpuFillCircleTb.sv
`timescale 1ns/100ps

module gpuFillCircleTb;
  import gpuPkg::*;

  localparam int widthBits = 6;
  localparam int heightBits = 6;
  localparam int screenWidth = 48;
  localparam int screenHeight = 40;

  typedef logic [widthBits-1:0] coord_t;
  typedef struct packed
  {
    coord_t xc;
    coord_t yc;
    coord_t rad;
    rgb_t color;
    logic scramble; // Random centre and colour on the inputs while busy.
    logic restart;  // Extra start edges while busy.
  } cmd_t;

  logic clk;
  logic n_rst;
  logic start_i;
  coord_t xC_i;
  coord_t yC_i;
  coord_t rad_i;
  rgb_t color_i;
  logic busy_o;
  logic done_o;
  logic pixelValid_o;
  coord_t pixelX_o;
  coord_t pixelY_o;
  rgb_t pixelColor_o;

  cmd_t cmdTable[$];
  string cmdNames[$];
  logic model [0:63][0:63];    // Expected coverage indexed by [y][x].
  logic observed [0:63][0:63];
  rgb_t expColor;
  logic [31:0] lfsrState;
  int errors;
  int testsRun;
  int testsFailed;
  int doneCount;
  int pixCount;
  int cycles;
  int cycleLimit = 100000;

  gpuFillCircle #(
    .widthBits(widthBits),
    .heightBits(heightBits),
    .screenWidth(screenWidth),
    .screenHeight(screenHeight)
  ) dut (
    .clk(clk),
    .n_rst(n_rst),
    .xC_i(xC_i),
    .yC_i(yC_i),
    .rad_i(rad_i),
    .color_i(color_i),
    .start_i(start_i),
    .busy_o(busy_o),
    .done_o(done_o),
    .pixelValid_o(pixelValid_o),
    .pixelX_o(pixelX_o),
    .pixelY_o(pixelY_o),
    .pixelColor_o(pixelColor_o)
  );

  initial clk = 1'b0;
  always #4 clk = !clk;

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycleLimit)
    begin
      $display("Timeout: the DUT did not finish within %0d cycles.", cycleLimit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Galois LFSR stepped once for each bit taken.
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
    end
    return v;
  endfunction

  task automatic checkBit(input string name, input logic expV, input logic actV);
    if (actV !== expV)
    begin
      errors++;
      $display("CHECK FAILED: %s expected %b actual %b", name, expV, actV);
    end
  endtask

  task automatic checkCoord(input string name, input coord_t expV, input coord_t actV);
    if (actV !== expV)
    begin
      errors++;
      $display("CHECK FAILED: %s expected %0d actual %0d", name, expV, actV);
    end
  endtask

  task automatic checkRgb(input string name, input rgb_t expV, input rgb_t actV);
    if (actV !== expV)
    begin
      errors++;
      $display("CHECK FAILED: %s expected %h actual %h", name, expV, actV);
    end
  endtask

  task automatic addEntry(input string name, input int xc, input int yc, input int r,
                          input logic [23:0] color, input logic scr, input logic rst);
    cmd_t c;
    c.xc = coord_t'(xc);
    c.yc = coord_t'(yc);
    c.rad = coord_t'(r);
    c.color = color;
    c.scramble = scr;
    c.restart = rst;
    cmdTable.push_back(c);
    cmdNames.push_back(name);
  endtask

  // Keeps xc + r and yc + r inside the signed span arithmetic of the DUT.
  task automatic addRandomEntry(input int idx);
    logic [31:0] v;
    int r;
    int xc;
    int yc;
    v = randBits(4);
    r = 2 + int'(v[3:0]);
    v = randBits(6);
    xc = (int'(v[5:0]) + r > 63) ? 63 - r : int'(v[5:0]);
    v = randBits(6);
    yc = (int'(v[5:0]) + r > 63) ? 63 - r : int'(v[5:0]);
    v = randBits(25);
    addEntry($sformatf("random%0d", idx), xc, yc, r, v[23:0], v[24], 1'b0);
  endtask

  task automatic markSpan(input int y, input int x0, input int x1);
    int x;
    if ((y >= 0) && (y < screenHeight))
    begin
      for (x = x0; x <= x1; x++)
      begin
        if ((x >= 0) && (x < screenWidth))
        begin
          model[y][x] = 1'b1;
        end
      end
    end
  endtask

  // Midpoint circle walk with four chords per step.
  task automatic buildModel(input cmd_t c);
    int xc;
    int yc;
    int a;
    int b;
    int d;
    xc = int'(c.xc);
    yc = int'(c.yc);
    a = 0;
    b = int'(c.rad);
    d = 1 - b;
    while (a <= b)
    begin
      markSpan(yc + a, xc - b, xc + b);
      markSpan(yc + b, xc - a, xc + a);
      markSpan(yc - a, xc - b, xc + b);
      markSpan(yc - b, xc - a, xc + a);
      if (d < 0)
      begin
        d = d + 2 * a + 3;
      end
      else
      begin
        d = d + 2 * (a - b) + 5;
        b = b - 1;
      end
      a = a + 1;
    end
  endtask

  task automatic clearMaps();
    int x;
    int y;
    for (y = 0; y < 64; y++)
    begin
      for (x = 0; x < 64; x++)
      begin
        model[y][x] = 1'b0;
        observed[y][x] = 1'b0;
      end
    end
  endtask

  // A filled circle row is one interval, so ends and count pin it down.
  task automatic compareMaps(input string name);
    int x;
    int y;
    coord_t expL;
    coord_t expR;
    coord_t expN;
    coord_t actL;
    coord_t actR;
    coord_t actN;
    for (y = 0; y < 64; y++)
    begin
      expL = '1;
      expR = '0;
      expN = '0;
      actL = '1;
      actR = '0;
      actN = '0;
      for (x = 0; x < 64; x++)
      begin
        if (model[y][x])
        begin
          expL = (expN == 0) ? coord_t'(x) : expL;
          expR = coord_t'(x);
          expN = expN + coord_t'(1);
        end
        if (observed[y][x])
        begin
          actL = (actN == 0) ? coord_t'(x) : actL;
          actR = coord_t'(x);
          actN = actN + coord_t'(1);
        end
      end
      checkCoord($sformatf("%s row %0d left", name, y), expL, actL);
      checkCoord($sformatf("%s row %0d right", name, y), expR, actR);
      checkCoord($sformatf("%s row %0d count", name, y), expN, actN);
    end
  endtask

  task automatic sampleOutputs(input string name);
    if (pixelValid_o === 1'b1)
    begin
      checkBit({name, " pixel on screen"}, 1'b1,
               (int'(pixelX_o) < screenWidth) && (int'(pixelY_o) < screenHeight));
      checkRgb({name, " pixel colour"}, expColor, pixelColor_o);
      observed[pixelY_o][pixelX_o] = 1'b1;
      pixCount++;
    end
    if (done_o === 1'b1)
    begin
      doneCount++;
      checkBit({name, " busy low at done"}, 1'b0, busy_o);
    end
  endtask

  task automatic scrambleInputs();
    logic [31:0] v;
    v = randBits(18);
    xC_i = v[5:0];
    yC_i = v[11:6];
    rad_i = v[17:12];
    v = randBits(24);
    color_i = v[23:0];
  endtask

  task automatic runTest(input int idx);
    cmd_t c;
    string name;
    int errBefore;
    c = cmdTable[idx];
    name = cmdNames[idx];
    errBefore = errors;
    clearMaps();
    buildModel(c);
    expColor = c.color;
    doneCount = 0;
    pixCount = 0;
    checkBit({name, " idle before start"}, 1'b0, busy_o);
    xC_i = c.xc;
    yC_i = c.yc;
    rad_i = c.rad;
    color_i = c.color;
    start_i = 1'b1;
    @(negedge clk);
    sampleOutputs(name);
    checkBit({name, " busy after start"}, 1'b1, busy_o);
    start_i = 1'b0;
    while (doneCount == 0)
    begin
      if (c.scramble)
      begin
        scrambleInputs();
      end
      if (c.restart)
      begin
        start_i = !start_i; // Every other cycle is a new rising edge.
      end
      @(negedge clk);
      sampleOutputs(name);
    end
    start_i = 1'b0;
    repeat (6)
    begin
      @(negedge clk);
      checkBit({name, " no pixel after done"}, 1'b0, pixelValid_o);
      sampleOutputs(name);
    end
    checkCoord({name, " done pulses"}, coord_t'(1), coord_t'(doneCount));
    compareMaps(name);
    testsRun++;
    if (errors != errBefore)
    begin
      testsFailed++;
    end
    $display("%s %s pixels=%0d", name, (errors == errBefore) ? "passed" : "FAILED", pixCount);
  endtask

  initial
  begin
    int i;
    int r;
    int errBefore;
    n_rst = 1'b0;
    start_i = 1'b0;
    xC_i = '0;
    yC_i = '0;
    rad_i = '0;
    color_i = '0;
    errors = 0;
    testsRun = 0;
    testsFailed = 0;
    cycles = 0;
    lfsrState = 32'h85b4_72a2;
    addEntry("radius0", 20, 20, 0, 24'hff0000, 1'b0, 1'b0);
    addEntry("small", 24, 20, 3, 24'h00ff00, 1'b0, 1'b0);
    addEntry("medium", 24, 20, 12, 24'h0000ff, 1'b0, 1'b0);
    addEntry("offCentre", 10, 12, 7, 24'h123456, 1'b0, 1'b0);
    addEntry("edgeLeft", 3, 20, 9, 24'habcdef, 1'b0, 1'b0);
    addEntry("edgeTop", 25, 2, 8, 24'h808080, 1'b0, 1'b0);
    addEntry("edgeCorner", 46, 38, 10, 24'hc0ffee, 1'b0, 1'b0);
    addEntry("scramble", 24, 20, 10, 24'h5a5aa5, 1'b1, 1'b0);
    addEntry("restart", 20, 18, 8, 24'h0f0f0f, 1'b0, 1'b1);
    for (i = 0; i < 4; i++)
    begin
      addRandomEntry(i);
    end
    cycleLimit = 100;
    for (i = 0; i < cmdTable.size(); i++)
    begin
      r = int'(cmdTable[i].rad);
      cycleLimit = cycleLimit + 16 * (r + 2) * (r + 2) + 32;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    n_rst = 1'b1;
    @(negedge clk);
    errBefore = errors;
    checkBit("reset busy", 1'b0, busy_o);
    checkBit("reset done", 1'b0, done_o);
    checkBit("reset pixelValid", 1'b0, pixelValid_o);
    testsRun++;
    if (errors != errBefore)
    begin
      testsFailed++;
    end
    $display("reset %s", (errors == errBefore) ? "passed" : "FAILED");
    for (i = 0; i < cmdTable.size(); i++)
    begin
      runTest(i);
    end
    $display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
             testsRun, testsFailed, errors);
    if (errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
design/gpuPkg.sv
design/circleCmdLatch.sv
design/midpointStepper.sv
design/spanSequencer.sv
design/pixelClipper.sv
design/gpuFillCircle.sv
verif/gpuFillCircleTb.sv

// File: run.sh
#!/bin/sh
# Build and run the filled-circle testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module gpuFillCircleTb \
  --Mdir obj_dir \
  -o gpuFillCircleSim \
  -f files.f

./obj_dir/gpuFillCircleSim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "Testbench reported failure."
  exit 1
fi

exit 0
